// ==== Makefile ====
# Verilator flow for the LSU mailbox bridge.

VERILATOR ?= verilator
TOP       ?= lsu_mem_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)
PASS_TEXT ?= all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# Pass only if the run prints the pass line.
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== filelist.f ====
hdl/lsu_mem_pkg.sv
hdl/word_ram.sv
hdl/lsu_mem_bridge.sv
hdl/host_mailbox_agent.sv
hdl/lsu_mem_top.sv
verification/lsu_mem_asserts.sv
verification/lsu_mem_tb.sv

// ==== hdl/host_mailbox_agent.sv ====
`default_nettype none

// Host side of the mailbox. ACK_DELAY >= 1, DONE_DELAY >= 2.
module host_mailbox_agent import lsu_mem_pkg::*; #(
  parameter int RAM_WORDS  = 256,
  parameter int ACK_DELAY  = 3,
  parameter int DONE_DELAY = 4
) (
  input  wire logic     clk,
  input  wire logic     rst,

  input  wire mb_op_e   mb_op,
  input  wire addr_t    mb_addr,
  input  wire data_t    mb_data_out,
  input  wire byte_en_t mb_byte_en,

  output logic          mb_ack,
  output logic          mb_done,
  output data_t         mb_data_in,
  output logic          mb_data_we,

  output logic          ram_en,
  output byte_en_t      ram_we,
  output logic [$clog2(RAM_WORDS)-1:0] ram_addr,
  output data_t         ram_wdata,
  input  wire data_t    ram_rdata
);

  localparam int AW      = $clog2(RAM_WORDS);
  localparam int MAX_DLY = (ACK_DELAY > DONE_DELAY) ? ACK_DELAY : DONE_DELAY;
  localparam int CNT_W   = $clog2(MAX_DLY + 1);

  localparam logic [CNT_W-1:0] ACK_CNT  = CNT_W'(ACK_DELAY - 2);
  localparam logic [CNT_W-1:0] DONE_CNT = CNT_W'(DONE_DELAY - 2);

  typedef enum logic [2:0] {
    AG_IDLE,
    AG_ACK_DLY,
    AG_RAM,
    AG_DONE_DLY,
    AG_DONE_HI
  } agent_state_e;

  agent_state_e     state;
  logic [CNT_W-1:0] cnt;
  logic             is_write;
  logic             ack_hold;
  logic             done_hold;
  logic             op_ack_wait;
  logic             done_fire;

  assign op_ack_wait = (mb_op == MB_WR_ACK_WAIT) || (mb_op == MB_RD_ACK_WAIT);
  assign done_fire   = (state == AG_DONE_DLY) && (cnt == '0);

  // One RAM cycle per access.
  assign ram_en    = (state == AG_RAM);
  assign ram_we    = (ram_en && is_write) ? mb_byte_en : '0;
  assign ram_addr  = mb_addr[WORD_LSB +: AW];  // Word index.
  assign ram_wdata = mb_data_out;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= AG_IDLE;
      cnt        <= '0;
      is_write   <= 1'b0;
      mb_ack     <= 1'b0;
      ack_hold   <= 1'b0;
      mb_done    <= 1'b0;
      done_hold  <= 1'b0;
      mb_data_we <= 1'b0;
    end else begin
      // Ack and done stay up two cycles.
      if (mb_ack) begin
        if (ack_hold) ack_hold <= 1'b0;
        else          mb_ack   <= 1'b0;
      end
      if (mb_done) begin
        if (done_hold) begin
          done_hold <= 1'b0;
        end else begin
          mb_done    <= 1'b0;
          mb_data_we <= 1'b0;
        end
      end

      case (state)
        AG_IDLE: begin
          if (op_ack_wait) begin
            is_write <= (mb_op == MB_WR_ACK_WAIT);
            if (ACK_DELAY <= 1) begin
              mb_ack   <= 1'b1;
              ack_hold <= 1'b1;
              state    <= AG_RAM;
            end else begin
              cnt   <= ACK_CNT;
              state <= AG_ACK_DLY;
            end
          end
        end
        AG_ACK_DLY: begin
          if (cnt == '0) begin
            mb_ack   <= 1'b1;
            ack_hold <= 1'b1;
            state    <= AG_RAM;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        AG_RAM: begin
          cnt   <= DONE_CNT;  // Counted from the ack.
          state <= AG_DONE_DLY;
        end
        AG_DONE_DLY: begin
          if (done_fire) begin
            mb_done    <= 1'b1;
            done_hold  <= 1'b1;
            mb_data_we <= ~is_write;
            state      <= AG_DONE_HI;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        AG_DONE_HI: begin
          if (mb_op == MB_IDLE) state <= AG_IDLE;  // Bridge closed the access.
        end
        default: state <= AG_IDLE;
      endcase
    end
  end

  // RAM output is stable here since ram_en was a cycle or more ago.
  always_ff @(posedge clk) begin
    if (done_fire) begin
      mb_data_in <= ram_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/lsu_mem_bridge.sv ====
`default_nettype none

module lsu_mem_bridge import lsu_mem_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst,

  // LSU request side.
  input  wire byte_en_t mem_wr_en,
  input  wire byte_en_t mem_rd_en,
  input  wire addr_t    mem_addr,
  input  wire data_t    mem_wr_data,
  input  wire tag_t     mem_tag_req,

  // LSU response side.
  output data_t         mem_rd_data,
  output tag_t          mem_tag_resp,
  output logic          mem_ack,

  // Mailbox from the host.
  input  wire data_t    mb_data_in,
  input  wire logic     mb_data_we,
  input  wire logic     mb_ack,
  input  wire logic     mb_done,

  // Mailbox to the host.
  output mb_op_e        mb_op,
  output data_t         mb_data_out,
  output addr_t         mb_addr,
  output byte_en_t      mb_byte_en
);

  mb_op_e state;
  mb_op_e state_next;

  logic mb_ack_q;
  logic mb_done_q;
  logic ack_rise;
  logic done_rise;
  logic req_wr;
  logic req_rd;
  logic req_take;

  assign req_wr    = |mem_wr_en;
  assign req_rd    = |mem_rd_en;
  assign req_take  = (state == MB_IDLE) && (req_wr || req_rd);  // Busy requests dropped.

  assign ack_rise  = mb_ack & ~mb_ack_q;
  assign done_rise = mb_done & ~mb_done_q;

  assign mb_op   = state;
  assign mem_ack = (state == MB_WR_LSU_ACK) || (state == MB_RD_LSU_ACK);

  // **********************************************************
  // State and edge detect registers
  // **********************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= MB_IDLE;
      mb_ack_q  <= 1'b0;
      mb_done_q <= 1'b0;
    end else begin
      state     <= state_next;
      mb_ack_q  <= mb_ack;
      mb_done_q <= mb_done;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      MB_IDLE: begin
        if (req_wr) begin
          state_next = MB_WR_ACK_WAIT;
        end else if (req_rd) begin
          state_next = MB_RD_ACK_WAIT;
        end
      end
      MB_WR_ACK_WAIT: begin
        if (ack_rise) state_next = MB_WR_DONE_WAIT;
      end
      MB_WR_DONE_WAIT: begin
        if (done_rise) state_next = MB_WR_LSU_ACK;
      end
      MB_WR_LSU_ACK:   state_next = MB_IDLE;
      MB_RD_ACK_WAIT: begin
        if (ack_rise) state_next = MB_RD_DONE_WAIT;
      end
      MB_RD_DONE_WAIT: begin
        if (done_rise) state_next = MB_RD_LSU_ACK;
      end
      MB_RD_LSU_ACK:   state_next = MB_IDLE;
      default:         state_next = MB_IDLE;
    endcase
  end

  // **********************************************************
  // Request and response payload
  // **********************************************************

  // Held stable for the whole access.
  always_ff @(posedge clk) begin
    if (req_take) begin
      mb_addr      <= mem_addr;
      mb_byte_en   <= req_wr ? mem_wr_en : mem_rd_en;
      mem_tag_resp <= mem_tag_req;  // Returned with mem_ack.
      if (req_wr) begin
        mb_data_out <= mem_wr_data;
      end
    end
  end

  // Read word arrives with the done strobe.
  always_ff @(posedge clk) begin
    if (state == MB_RD_DONE_WAIT && mb_data_we) begin
      mem_rd_data <= mb_data_in;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/lsu_mem_pkg.sv ====
`default_nettype none

package lsu_mem_pkg;

  // **********************************************************
  // Widths
  // **********************************************************

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BYTE_W = 8;
  localparam int BE_W   = DATA_W / BYTE_W;
  localparam int TAG_W  = 7;

  // Byte offset bits below the word index.
  localparam int WORD_LSB = $clog2(BE_W);

  typedef logic [ADDR_W-1:0] addr_t;     // Byte address.
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BE_W-1:0]   byte_en_t;  // One bit per byte lane.
  typedef logic [TAG_W-1:0]  tag_t;

  // **********************************************************
  // Mailbox op codes
  // **********************************************************

  // Bridge state, seen by the host as the op code.
  typedef enum logic [3:0] {
    MB_IDLE         = 4'd0,
    MB_WR_ACK_WAIT  = 4'd1,
    MB_WR_DONE_WAIT = 4'd2,
    MB_WR_LSU_ACK   = 4'd3,
    MB_RD_ACK_WAIT  = 4'd4,
    MB_RD_DONE_WAIT = 4'd5,
    MB_RD_LSU_ACK   = 4'd6
  } mb_op_e;

endpackage

`default_nettype wire

// ==== hdl/lsu_mem_top.sv ====
`default_nettype none

module lsu_mem_top import lsu_mem_pkg::*; #(
  parameter int RAM_WORDS  = 256,
  parameter int ACK_DELAY  = 3,
  parameter int DONE_DELAY = 4
) (
  input  wire logic     clk,
  input  wire logic     rst,

  input  wire byte_en_t mem_wr_en,
  input  wire byte_en_t mem_rd_en,
  input  wire addr_t    mem_addr,
  input  wire data_t    mem_wr_data,
  input  wire tag_t     mem_tag_req,

  output data_t         mem_rd_data,
  output tag_t          mem_tag_resp,
  output logic          mem_ack
);

  // Mailbox.
  mb_op_e   mb_op;
  addr_t    mb_addr;
  data_t    mb_data_out;
  byte_en_t mb_byte_en;
  data_t    mb_data_in;
  logic     mb_data_we;
  logic     mb_ack;
  logic     mb_done;

  // RAM port.
  logic     ram_en;
  byte_en_t ram_we;
  logic [$clog2(RAM_WORDS)-1:0] ram_addr;
  data_t    ram_wdata;
  data_t    ram_rdata;

  lsu_mem_bridge u_bridge (
    .clk          (clk),
    .rst          (rst),
    .mem_wr_en    (mem_wr_en),
    .mem_rd_en    (mem_rd_en),
    .mem_addr     (mem_addr),
    .mem_wr_data  (mem_wr_data),
    .mem_tag_req  (mem_tag_req),
    .mem_rd_data  (mem_rd_data),
    .mem_tag_resp (mem_tag_resp),
    .mem_ack      (mem_ack),
    .mb_data_in   (mb_data_in),
    .mb_data_we   (mb_data_we),
    .mb_ack       (mb_ack),
    .mb_done      (mb_done),
    .mb_op        (mb_op),
    .mb_data_out  (mb_data_out),
    .mb_addr      (mb_addr),
    .mb_byte_en   (mb_byte_en)
  );

  host_mailbox_agent #(
    .RAM_WORDS  (RAM_WORDS),
    .ACK_DELAY  (ACK_DELAY),
    .DONE_DELAY (DONE_DELAY)
  ) u_agent (
    .clk         (clk),
    .rst         (rst),
    .mb_op       (mb_op),
    .mb_addr     (mb_addr),
    .mb_data_out (mb_data_out),
    .mb_byte_en  (mb_byte_en),
    .mb_ack      (mb_ack),
    .mb_done     (mb_done),
    .mb_data_in  (mb_data_in),
    .mb_data_we  (mb_data_we),
    .ram_en      (ram_en),
    .ram_we      (ram_we),
    .ram_addr    (ram_addr),
    .ram_wdata   (ram_wdata),
    .ram_rdata   (ram_rdata)
  );

  word_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) u_ram (
    .clk       (clk),
    .ram_en    (ram_en),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata)
  );

endmodule

`default_nettype wire

// ==== hdl/word_ram.sv ====
`default_nettype none

module word_ram import lsu_mem_pkg::*; #(
  parameter int RAM_WORDS = 256
) (
  input  wire logic     clk,
  input  wire logic     ram_en,
  input  wire byte_en_t ram_we,
  input  wire logic [$clog2(RAM_WORDS)-1:0] ram_addr,
  input  wire data_t    ram_wdata,
  output data_t         ram_rdata
);

  data_t mem [RAM_WORDS];

  // Zero-filled at start.
  initial begin
    for (int w = 0; w < RAM_WORDS; w++) begin
      mem[w] = '0;
    end
  end

  // **********************************************************
  // Byte-lane write, registered read
  // **********************************************************

  always_ff @(posedge clk) begin
    if (ram_en) begin
      for (int b = 0; b < BE_W; b++) begin
        if (ram_we[b]) begin
          mem[ram_addr][b*BYTE_W +: BYTE_W] <= ram_wdata[b*BYTE_W +: BYTE_W];
        end
      end
    end
  end

  // Old data on a write cycle.
  always_ff @(posedge clk) begin
    if (ram_en) begin
      ram_rdata <= mem[ram_addr];
    end
  end

endmodule

`default_nettype wire

// ==== verification/lsu_mem_asserts.sv ====
`default_nettype none

module lsu_mem_asserts import lsu_mem_pkg::*; (
  input wire logic   clk,
  input wire logic   rst,
  input wire logic   mem_ack,
  input wire mb_op_e mb_op,
  input wire addr_t  mb_addr
);

  timeunit 1ns;
  timeprecision 1ps;

  // **********************************************************
  // Bridge protocol
  // **********************************************************

  ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
      mem_ack |=> !mem_ack)
    else $error("mem_ack stayed high for more than one cycle");

  op_legal: assert property (@(posedge clk) disable iff (rst)
      mb_op inside {MB_IDLE, MB_WR_ACK_WAIT, MB_WR_DONE_WAIT, MB_WR_LSU_ACK,
                    MB_RD_ACK_WAIT, MB_RD_DONE_WAIT, MB_RD_LSU_ACK})
    else $error("mb_op holds an undefined op code");

  // Loaded only in idle.
  addr_stable: assert property (@(posedge clk) disable iff (rst)
      (mb_op != MB_IDLE) |=> $stable(mb_addr))
    else $error("mb_addr changed during an access");

  // LSU_ACK of the same direction, straight after its done wait.
  ack_in_lsu_ack: assert property (@(posedge clk) disable iff (rst)
      mem_ack |-> ((mb_op == MB_WR_LSU_ACK && $past(mb_op) == MB_WR_DONE_WAIT) ||
                   (mb_op == MB_RD_LSU_ACK && $past(mb_op) == MB_RD_DONE_WAIT)))
    else $error("mem_ack high outside an LSU_ACK state entered from its done wait");

endmodule

`default_nettype wire

// ==== verification/lsu_mem_patterns.txt ====
// op be addr wdata tag exp (hex). op 1 is a write, 2 a read, 0 ends the list.
// exp is the read word the access must return; writes list zero there.
1 f 00000010 deadbeef 01 00000000
2 f 00000010 00000000 02 deadbeef
1 3 00000010 1234a5c3 03 00000000
2 f 00000010 00000000 04 deada5c3
1 4 00000020 11223344 7f 00000000
2 f 00000020 00000000 55 00220000
1 9 00000020 aabbccdd 2a 00000000
2 f 00000020 00000000 00 aa2200dd
1 f 00000100 01020304 10 00000000
1 f 00000104 05060708 11 00000000
2 f 00000100 00000000 12 01020304
1 f 00000100 cafef00d 13 00000000
2 f 00000104 00000000 14 05060708
2 f 00000100 00000000 15 cafef00d
2 f 000003fc 00000000 16 00000000
2 f 00000200 00000000 17 00000000
1 2 000003fc 0000ab00 18 00000000
2 f 000003fc 00000000 19 0000ab00
0 0 00000000 00000000 00 00000000

// ==== verification/lsu_mem_tb.sv ====
`default_nettype none

module lsu_mem_tb import lsu_mem_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD     = 20;
  localparam int RESET_CYCLES   = 16;
  localparam int ACCESS_TIMEOUT = 64;
  localparam int MAX_PATTERNS   = 32;
  localparam int FIELDS         = 6;  // op, be, addr, wdata, tag, exp.
  localparam logic [16:0] LFSR_SEED = 17'd92334;
  localparam string PATTERN_FILE = "verification/lsu_mem_patterns.txt";

  logic     clk = 1'b0;
  logic     rst;
  byte_en_t mem_wr_en;
  byte_en_t mem_rd_en;
  addr_t    mem_addr;
  data_t    mem_wr_data;
  tag_t     mem_tag_req;
  data_t    mem_rd_data;
  tag_t     mem_tag_resp;
  logic     mem_ack;

  logic [31:0] pat_mem [0:FIELDS*MAX_PATTERNS-1];
  int          n_patterns = 0;
  logic [16:0] lfsr_state = LFSR_SEED;
  data_t       model_mem [addr_t];  // Word address to contents, zero if absent.

  always #(CLK_PERIOD / 2) clk = ~clk;

  lsu_mem_top u_lsu_mem_top (
    .clk          (clk),
    .rst          (rst),
    .mem_wr_en    (mem_wr_en),
    .mem_rd_en    (mem_rd_en),
    .mem_addr     (mem_addr),
    .mem_wr_data  (mem_wr_data),
    .mem_tag_req  (mem_tag_req),
    .mem_rd_data  (mem_rd_data),
    .mem_tag_resp (mem_tag_resp),
    .mem_ack      (mem_ack)
  );

  bind lsu_mem_bridge lsu_mem_asserts u_bridge_asserts (
    .clk     (clk),
    .rst     (rst),
    .mem_ack (mem_ack),
    .mb_op   (mb_op),
    .mb_addr (mb_addr)
  );

  // **********************************************************
  // Helpers
  // **********************************************************

  task automatic stop_on_error();
    $display("tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic load_patterns();
    for (int i = 0; i < FIELDS * MAX_PATTERNS; i++) pat_mem[i] = '0;
    $readmemh(PATTERN_FILE, pat_mem);
    while (n_patterns < MAX_PATTERNS && pat_mem[FIELDS*n_patterns] != 0) n_patterns++;
  endtask

  // x^17 + x^14 + 1.
  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  task automatic take_bit(output logic b);
    b = lfsr_state[16];
    lfsr_state = lfsr_next(lfsr_state);
  endtask

  task automatic next_gap(output int gap);
    logic b;
    gap = 0;
    for (int i = 0; i < 3; i++) begin
      take_bit(b);
      gap = (gap << 1) | int'(b);
    end
  endtask

  function automatic data_t model_read(input addr_t addr);
    addr_t key;
    key = addr & 32'hffff_fffc;
    return model_mem.exists(key) ? model_mem[key] : '0;
  endfunction

  function automatic void model_write(input addr_t addr, input byte_en_t be, input data_t wdata);
    data_t word;
    word = model_read(addr);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) word[b*8 +: 8] = wdata[b*8 +: 8];  // Enabled lanes only.
    end
    model_mem[addr & 32'hffff_fffc] = word;
  endfunction

  task automatic check_ack_low();
    @(negedge clk);
    assert (mem_ack === 1'b0) else begin
      $display("MISMATCH at %0t: mem_ack got %b expected 0", $time, mem_ack);
      stop_on_error();
    end
  endtask

  // One-cycle request, held on the LSU side only for the sampling edge.
  task automatic drive_request(input logic wr, input byte_en_t be, input addr_t addr,
                               input data_t wdata, input tag_t tag);
    @(posedge clk);
    mem_wr_en   <= wr ? be : '0;
    mem_rd_en   <= wr ? '0 : be;
    mem_addr    <= addr;
    mem_wr_data <= wdata;
    mem_tag_req <= tag;
    @(posedge clk);
    mem_wr_en <= '0;
    mem_rd_en <= '0;
  endtask

  task automatic wait_for_ack(output bit seen);
    int cycles;
    seen = 1'b0;
    cycles = 0;
    while (!seen && cycles < ACCESS_TIMEOUT) begin
      @(negedge clk);
      if (mem_ack === 1'b1) seen = 1'b1;
      else cycles++;
    end
  endtask

  task automatic run_access(input int p);
    logic     wr;
    byte_en_t be;
    addr_t    addr;
    data_t    wdata;
    tag_t     tag;
    data_t    exp_file;
    data_t    exp_model;
    bit       seen;
    wr        = (pat_mem[FIELDS*p][3:0] == 4'd1);
    be        = pat_mem[FIELDS*p+1][3:0];
    addr      = pat_mem[FIELDS*p+2];
    wdata     = pat_mem[FIELDS*p+3];
    tag       = pat_mem[FIELDS*p+4][6:0];
    exp_file  = pat_mem[FIELDS*p+5];
    drive_request(wr, be, addr, wdata, tag);
    wait_for_ack(seen);
    assert (seen) else begin
      $display("ERROR: no mem_ack within %0d cycles for pattern %0d at %0t",
               ACCESS_TIMEOUT, p, $time);
      stop_on_error();
    end
    assert (mem_tag_resp === tag) else begin
      $display("MISMATCH at %0t: mem_tag_resp got %h expected %h", $time, mem_tag_resp, tag);
      stop_on_error();
    end
    if (wr) begin
      model_write(addr, be, wdata);
    end else begin
      exp_model = model_read(addr);
      assert (exp_model === exp_file) else begin
        $display("ERROR: pattern %0d lists %h but the memory model holds %h",
                 p, exp_file, exp_model);
        stop_on_error();
      end
      assert (mem_rd_data === exp_model) else begin
        $display("MISMATCH at %0t: mem_rd_data got %h expected %h",
                 $time, mem_rd_data, exp_model);
        stop_on_error();
      end
    end
    check_ack_low();  // Single-cycle pulse.
  endtask

  // **********************************************************
  // Sequence and watchdog
  // **********************************************************

  initial begin : main_seq
    int gap;
    rst         = 1'b1;
    mem_wr_en   = '0;
    mem_rd_en   = '0;
    mem_addr    = '0;
    mem_wr_data = '0;
    mem_tag_req = '0;
    load_patterns();
    assert (n_patterns > 0) else begin
      $display("ERROR: no patterns could be read from %s", PATTERN_FILE);
      stop_on_error();
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    repeat (4) check_ack_low();  // Quiet before the first request.
    for (int p = 0; p < n_patterns; p++) begin
      next_gap(gap);
      repeat (gap) check_ack_low();
      run_access(p);
    end
    $display("all tests passed");
    $finish;
  end

  initial begin : watchdog
    wait (n_patterns > 0);
    #((RESET_CYCLES + n_patterns * 64) * CLK_PERIOD);
    $display("ERROR: watchdog expired at %0t before all accesses completed", $time);
    $display("tests failed");
    $fatal(1, "watchdog timeout");
  end

endmodule

`default_nettype wire
